//--- design/lsu_agu.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_agu import lsu_pkg::*; (
    input  logic      lsu_valid_i,
    input  lsu_req_t  lsu_req_i,
    output lsu_ctrl_t ctrl_o
);

    logic [`LSU_XLEN-1:0] offset;
    logic [`LSU_XLEN-1:0] sum;
    logic [7:0]           be_mask;
    dcs_t                 dcs;

    // ---------------------------------------------------------------------------
    // offset and coherence hint decoding
    // ---------------------------------------------------------------------------
    always_comb begin
        dcs    = '0;
        offset = {{(`LSU_XLEN-12){lsu_req_i.imm[11]}}, lsu_req_i.imm};
        if (lsu_req_i.use_dcs) begin
            dcs.en             = 1'b1;
            dcs.dcs            = lsu_req_i.imm[10:9];
            dcs.cid            = lsu_req_i.imm[8:5];
            dcs.use_owner_pred = lsu_req_i.imm[4];
            if (lsu_req_i.imm[4]) begin
                // owner prediction, only 4 offset bits left
                offset = {{(`LSU_XLEN-4){lsu_req_i.imm[3]}}, lsu_req_i.imm[3:0]};
            end else begin
                // cid bits double as upper offset
                offset = {{(`LSU_XLEN-8){lsu_req_i.imm[8]}},
                          lsu_req_i.imm[8:5], lsu_req_i.imm[3:0]};
            end
        end
    end

    // full width sum
    assign sum = lsu_req_i.operand_a + offset;

    // ---------------------------------------------------------------------------
    // byte enables
    // ---------------------------------------------------------------------------
    always_comb begin
        unique case (op_size(lsu_req_i.operator))
            2'd1:    be_mask = 8'h03;
            2'd2:    be_mask = 8'h0f;
            2'd3:    be_mask = 8'hff;
            default: be_mask = 8'h01;
        endcase
    end

    // ---------------------------------------------------------------------------
    // control word
    // ---------------------------------------------------------------------------
    assign ctrl_o.valid    = lsu_valid_i;
    assign ctrl_o.vaddr    = sum[`LSU_VLEN-1:0];
    // upper bits must be a sign extension of bit vlen-1
    assign ctrl_o.overflow = ~((&sum[`LSU_XLEN-1:`LSU_VLEN-1]) |
                               ~(|sum[`LSU_XLEN-1:`LSU_VLEN-1]));
    assign ctrl_o.data     = lsu_req_i.operand_b;
    // shift out of the doubleword is dropped
    assign ctrl_o.be       = be_mask << sum[2:0];
    assign ctrl_o.operator = lsu_req_i.operator;
    assign ctrl_o.trans_id = lsu_req_i.trans_id;
    assign ctrl_o.dcs      = dcs;

endmodule

//--- design/lsu_bypass.sv
`timescale 1ns/1ps

module lsu_bypass import lsu_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      flush_i,
    input  lsu_ctrl_t req_i,
    input  logic      pop_ld_i,
    input  logic      pop_st_i,
    output lsu_ctrl_t ctrl_o,
    output logic      ready_o
);

    // two entry store
    lsu_ctrl_t [1:0] mem_q;
    logic [1:0]      vld_q;
    logic [1:0]      vld_n;
    logic            rd_ptr_q;
    logic            rd_ptr_n;
    logic            wr_ptr_q;
    logic            wr_ptr_n;
    logic [1:0]      cnt_q;
    logic [1:0]      cnt_n;

    logic push;
    logic pop;
    logic empty;

    assign push    = req_i.valid;
    // only the head pops, so at most one of the two
    assign pop     = pop_ld_i | pop_st_i;
    assign empty   = (cnt_q == 2'd0);
    assign ready_o = empty;

    // ---------------------------------------------------------------------------
    // pointer and count update
    // ---------------------------------------------------------------------------
    always_comb begin
        vld_n    = vld_q;
        rd_ptr_n = rd_ptr_q;
        wr_ptr_n = wr_ptr_q;
        cnt_n    = cnt_q;

        if (push) begin
            vld_n[wr_ptr_q] = 1'b1;
            wr_ptr_n        = ~wr_ptr_q;
        end
        // pop after push, so a same cycle pass through leaves nothing behind
        if (pop) begin
            vld_n[rd_ptr_q] = 1'b0;
            rd_ptr_n        = ~rd_ptr_q;
        end

        unique case ({push, pop})
            2'b10:   cnt_n = cnt_q + 2'd1;
            2'b01:   cnt_n = cnt_q - 2'd1;
            default: cnt_n = cnt_q;
        endcase

        if (flush_i) begin
            vld_n    = '0;
            rd_ptr_n = 1'b0;
            wr_ptr_n = 1'b0;
            cnt_n    = '0;
        end
    end

    // ---------------------------------------------------------------------------
    // head selection
    // ---------------------------------------------------------------------------
    always_comb begin
        if (empty) begin
            // transparent
            ctrl_o = req_i;
        end else begin
            ctrl_o       = mem_q[rd_ptr_q];
            ctrl_o.valid = vld_q[rd_ptr_q];
        end
    end

    // payload only
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= req_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            vld_q    <= '0;
            rd_ptr_q <= 1'b0;
            wr_ptr_q <= 1'b0;
            cnt_q    <= '0;
        end else begin
            vld_q    <= vld_n;
            rd_ptr_q <= rd_ptr_n;
            wr_ptr_q <= wr_ptr_n;
            cnt_q    <= cnt_n;
        end
    end

endmodule

//--- design/lsu_dispatch.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_dispatch import lsu_pkg::*; (
    input  logic       en_ld_st_translation_i,
    input  logic       pop_ld_i,
    input  logic       pop_st_i,
    input  lsu_ctrl_t  ctrl_i,
    output lsu_issue_t ld_issue_o,
    output lsu_issue_t st_issue_o,
    output lsu_wb_t    ld_wb_o,
    output lsu_wb_t    st_wb_o
);

    logic       is_store;
    logic       misaligned;
    lsu_ex_t    ex;
    lsu_issue_t issue;

    assign is_store = op_is_store(ctrl_i.operator);

    // ---------------------------------------------------------------------------
    // alignment check
    // ---------------------------------------------------------------------------
    always_comb begin
        unique case (op_size(ctrl_i.operator))
            // half word
            2'd1:    misaligned = ctrl_i.vaddr[0];
            // word
            2'd2:    misaligned = (ctrl_i.vaddr[1:0] != 2'b00);
            // double word
            2'd3:    misaligned = (ctrl_i.vaddr[2:0] != 3'b000);
            // bytes never misalign
            default: misaligned = 1'b0;
        endcase
    end

    // ---------------------------------------------------------------------------
    // exception
    // ---------------------------------------------------------------------------
    always_comb begin
        ex = '0;
        if (ctrl_i.valid && misaligned) begin
            ex.valid = 1'b1;
            ex.cause = is_store ? `LSU_CAUSE_BITS'(`LSU_ST_MISALIGNED)
                                : `LSU_CAUSE_BITS'(`LSU_LD_MISALIGNED);
            ex.tval  = ctrl_i.vaddr;
        end
        // access fault overrides misalignment
        if (ctrl_i.valid && en_ld_st_translation_i && ctrl_i.overflow) begin
            ex.valid = 1'b1;
            ex.cause = is_store ? `LSU_CAUSE_BITS'(`LSU_ST_ACCESS_FAULT)
                                : `LSU_CAUSE_BITS'(`LSU_LD_ACCESS_FAULT);
            ex.tval  = ctrl_i.vaddr;
        end
    end

    // ---------------------------------------------------------------------------
    // issue steering
    // ---------------------------------------------------------------------------
    // common fields of both ports
    assign issue.valid    = ctrl_i.valid;
    assign issue.vaddr    = ctrl_i.vaddr;
    assign issue.be       = ctrl_i.be;
    assign issue.operator = ctrl_i.operator;
    assign issue.data     = ctrl_i.data;
    assign issue.trans_id = ctrl_i.trans_id;
    assign issue.dcs      = ctrl_i.dcs;

    always_comb begin
        ld_issue_o       = issue;
        ld_issue_o.valid = issue.valid & ~is_store;
        st_issue_o       = issue;
        st_issue_o.valid = issue.valid & is_store;
    end

    // ---------------------------------------------------------------------------
    // writeback reports
    // ---------------------------------------------------------------------------
    // one report per pop, head still in place this cycle
    always_comb begin
        ld_wb_o = '0;
        st_wb_o = '0;
        if (pop_ld_i) begin
            ld_wb_o.valid    = 1'b1;
            ld_wb_o.trans_id = ctrl_i.trans_id;
            ld_wb_o.ex       = ex;
        end
        if (pop_st_i) begin
            st_wb_o.valid    = 1'b1;
            st_wb_o.trans_id = ctrl_i.trans_id;
            st_wb_o.ex       = ex;
        end
    end

endmodule

//--- design/lsu_front.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_front import lsu_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       flush_i,
    input  logic       lsu_valid_i,
    input  lsu_req_t   lsu_req_i,
    input  logic       en_ld_st_translation_i,
    input  logic       pop_ld_i,
    input  logic       pop_st_i,
    output logic       lsu_ready_o,
    output lsu_issue_t ld_issue_o,
    output lsu_issue_t st_issue_o,
    output lsu_wb_t    ld_wb_o,
    output lsu_wb_t    st_wb_o
);

    // agu result
    lsu_ctrl_t req_ctrl;
    // buffer head
    lsu_ctrl_t head_ctrl;
    // unregistered reports
    lsu_wb_t   ld_wb;
    lsu_wb_t   st_wb;

    // ---------------------------------------------------------------------------
    // address generation and buffering
    // ---------------------------------------------------------------------------
    lsu_agu i_agu (
        .lsu_valid_i ( lsu_valid_i ),
        .lsu_req_i   ( lsu_req_i   ),
        .ctrl_o      ( req_ctrl    )
    );

    lsu_bypass i_bypass (
        .clk_i    ( clk_i       ),
        .rst_ni   ( rst_ni      ),
        .flush_i  ( flush_i     ),
        .req_i    ( req_ctrl    ),
        .pop_ld_i ( pop_ld_i    ),
        .pop_st_i ( pop_st_i    ),
        .ctrl_o   ( head_ctrl   ),
        .ready_o  ( lsu_ready_o )
    );

    lsu_dispatch i_dispatch (
        .en_ld_st_translation_i ( en_ld_st_translation_i ),
        .pop_ld_i               ( pop_ld_i               ),
        .pop_st_i               ( pop_st_i               ),
        .ctrl_i                 ( head_ctrl              ),
        .ld_issue_o             ( ld_issue_o             ),
        .st_issue_o             ( st_issue_o             ),
        .ld_wb_o                ( ld_wb                  ),
        .st_wb_o                ( st_wb                  )
    );

    // ---------------------------------------------------------------------------
    // writeback pipelines
    // ---------------------------------------------------------------------------
    lsu_pipe_reg #(
        .Depth ( `LSU_LD_PIPE_REGS )
    ) i_pipe_ld (
        .clk_i  ( clk_i   ),
        .rst_ni ( rst_ni  ),
        .d_i    ( ld_wb   ),
        .d_o    ( ld_wb_o )
    );

    lsu_pipe_reg #(
        .Depth ( `LSU_ST_PIPE_REGS )
    ) i_pipe_st (
        .clk_i  ( clk_i   ),
        .rst_ni ( rst_ni  ),
        .d_i    ( st_wb   ),
        .d_o    ( st_wb_o )
    );

endmodule

//--- design/lsu_params.svh
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// ---------------------------------------------------------------------------
// widths
// ---------------------------------------------------------------------------
// sv39 virtual address
`define LSU_VLEN 39
`define LSU_XLEN 64
`define LSU_TID_BITS 3
`define LSU_CAUSE_BITS 4

// ---------------------------------------------------------------------------
// exception causes
// ---------------------------------------------------------------------------
`define LSU_LD_MISALIGNED 4
`define LSU_LD_ACCESS_FAULT 5
`define LSU_ST_MISALIGNED 6
`define LSU_ST_ACCESS_FAULT 7

// ---------------------------------------------------------------------------
// writeback pipeline depths
// ---------------------------------------------------------------------------
`define LSU_LD_PIPE_REGS 1
`define LSU_ST_PIPE_REGS 2

`endif

//--- design/lsu_pipe_reg.sv
`timescale 1ns/1ps

module lsu_pipe_reg import lsu_pkg::*; #(
    parameter int unsigned Depth = 1
) (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  lsu_wb_t d_i,
    output lsu_wb_t d_o
);

    // stage 0 takes the input
    lsu_wb_t [Depth-1:0] stage_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            stage_q <= '0;
        end else begin
            stage_q[0] <= d_i;
            // every stage moves each cycle
            for (int i = 1; i < Depth; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // last stage out
    assign d_o = stage_q[Depth-1];

endmodule

//--- design/lsu_pkg.sv
`include "lsu_params.svh"

package lsu_pkg;

    // ---------------------------------------------------------------------------
    // operators
    // ---------------------------------------------------------------------------
    // loads first, then stores
    typedef enum logic [3:0] {
        LB,
        LBU,
        LH,
        LHU,
        LW,
        LWU,
        LD,
        SB,
        SH,
        SW,
        SD
    } lsu_op_e;

    // incoming request from issue
    typedef struct packed {
        lsu_op_e                   operator;
        logic [`LSU_XLEN-1:0]      operand_a;
        logic [`LSU_XLEN-1:0]      operand_b;
        logic [11:0]               imm;
        logic [`LSU_TID_BITS-1:0]  trans_id;
        // imm carries coherence hints
        logic                      use_dcs;
    } lsu_req_t;

    // coherence hint fields
    typedef struct packed {
        logic       en;
        logic [1:0] dcs;
        logic [3:0] cid;
        logic       use_owner_pred;
    } dcs_t;

    // agu result, held in the bypass buffer
    typedef struct packed {
        logic                      valid;
        logic [`LSU_VLEN-1:0]      vaddr;
        logic                      overflow;
        logic [`LSU_XLEN-1:0]      data;
        logic [7:0]                be;
        lsu_op_e                   operator;
        logic [`LSU_TID_BITS-1:0]  trans_id;
        dcs_t                      dcs;
    } lsu_ctrl_t;

    // one per issue port
    typedef struct packed {
        logic                      valid;
        logic [`LSU_VLEN-1:0]      vaddr;
        logic [7:0]                be;
        lsu_op_e                   operator;
        logic [`LSU_XLEN-1:0]      data;
        logic [`LSU_TID_BITS-1:0]  trans_id;
        dcs_t                      dcs;
    } lsu_issue_t;

    typedef struct packed {
        logic                       valid;
        logic [`LSU_CAUSE_BITS-1:0] cause;
        logic [`LSU_VLEN-1:0]       tval;
    } lsu_ex_t;

    // writeback report
    typedef struct packed {
        logic                      valid;
        logic [`LSU_TID_BITS-1:0]  trans_id;
        lsu_ex_t                   ex;
    } lsu_wb_t;

    // store class of an operator
    function automatic logic op_is_store(lsu_op_e op);
        return op inside {SB, SH, SW, SD};
    endfunction

    // log2 of the access size in bytes
    function automatic logic [1:0] op_size(lsu_op_e op);
        logic [1:0] size;
        unique case (op)
            LH, LHU, SH: size = 2'd1;
            LW, LWU, SW: size = 2'd2;
            LD, SD:      size = 2'd3;
            default:     size = 2'd0;
        endcase
        return size;
    endfunction

endpackage

//--- run.sh
#!/bin/sh
# build and run the lsu_front testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_lsu_front -f verilog.f

# pass only if the testbench printed its pass line
./obj_dir/Vtb_lsu_front +verilator+error+limit+1000 | tee /dev/stderr | grep -qx "TEST OK"

//--- tb/lsu_front_asserts.sv
`timescale 1ns/1ps

module lsu_front_asserts import lsu_pkg::*; (
    input logic       clk_i,
    input logic       rst_ni,
    input logic       flush_i,
    input logic       pop_ld_i,
    input logic       pop_st_i,
    input logic       ready_i,
    input lsu_issue_t ld_issue_i,
    input lsu_issue_t st_issue_i
);

    // assertion failures so far
    int unsigned fail_cnt = 0;

    // ---------------------------------------------------------------------------
    // buffer and port properties
    // ---------------------------------------------------------------------------
    // buffer empty right after a flush
    a_ready_after_flush: assert property (
        @(posedge clk_i) disable iff (!rst_ni) flush_i |=> ready_i
    ) else begin
        fail_cnt++;
        $error("lsu_ready_o low in the cycle after flush");
    end

    // downstream pops only a valid head
    a_pop_ld_valid: assert property (
        @(posedge clk_i) disable iff (!rst_ni) pop_ld_i |-> ld_issue_i.valid
    ) else begin
        fail_cnt++;
        $error("pop_ld_i with no valid load issue");
    end

    a_pop_st_valid: assert property (
        @(posedge clk_i) disable iff (!rst_ni) pop_st_i |-> st_issue_i.valid
    ) else begin
        fail_cnt++;
        $error("pop_st_i with no valid store issue");
    end

    // one head, one port
    a_one_port: assert property (
        @(posedge clk_i) disable iff (!rst_ni) !(ld_issue_i.valid && st_issue_i.valid)
    ) else begin
        fail_cnt++;
        $error("load and store issue valid together");
    end

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // reset low for the first 3 cycles
    initial begin
        rst_no = 1'b0;
        repeat (3) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

//--- tb/tb_lsu_front.sv
`timescale 1ns/1ps
`include "lsu_params.svh"

module tb_lsu_front import lsu_pkg::*; ();

    // one table row, stimulus then expected values
    typedef struct packed {
        lsu_op_e                    op;
        logic [`LSU_XLEN-1:0]       a;
        logic [11:0]                imm;
        logic                       use_dcs;
        logic [`LSU_TID_BITS-1:0]   tid;
        logic                       xlat;
        logic [1:0]                 hold;
        logic                       rnd;
        logic [`LSU_VLEN-1:0]       vaddr;
        logic [7:0]                 be;
        logic [7:0]                 dcs;
        logic                       store;
        logic                       ex;
        logic [`LSU_CAUSE_BITS-1:0] cause;
    } row_t;

    localparam int NUM_ROWS    = 17;
    localparam int CYCLE_LIMIT = 20 * NUM_ROWS + 50;

    logic       clk;
    logic       rst_n;
    logic       flush_i;
    logic       lsu_valid_i;
    lsu_req_t   lsu_req_i;
    logic       en_ld_st_translation_i;
    logic       pop_ld_i;
    logic       pop_st_i;
    logic       lsu_ready_o;
    lsu_issue_t ld_issue_o;
    lsu_issue_t st_issue_o;
    lsu_wb_t    ld_wb_o;
    lsu_wb_t    st_wb_o;

    row_t        rows [NUM_ROWS];
    int          errors = 0;
    int          cycles = 0;

    tb_clock_gen i_clk (
        .clk_o  ( clk   ),
        .rst_no ( rst_n )
    );

    lsu_front dut (
        .clk_i                  ( clk                    ),
        .rst_ni                 ( rst_n                  ),
        .flush_i                ( flush_i                ),
        .lsu_valid_i            ( lsu_valid_i            ),
        .lsu_req_i              ( lsu_req_i              ),
        .en_ld_st_translation_i ( en_ld_st_translation_i ),
        .pop_ld_i               ( pop_ld_i               ),
        .pop_st_i               ( pop_st_i               ),
        .lsu_ready_o            ( lsu_ready_o            ),
        .ld_issue_o             ( ld_issue_o             ),
        .st_issue_o             ( st_issue_o             ),
        .ld_wb_o                ( ld_wb_o                ),
        .st_wb_o                ( st_wb_o                )
    );

    bind lsu_front lsu_front_asserts i_asserts (
        .clk_i      ( clk_i       ),
        .rst_ni     ( rst_ni      ),
        .flush_i    ( flush_i     ),
        .pop_ld_i   ( pop_ld_i    ),
        .pop_st_i   ( pop_st_i    ),
        .ready_i    ( lsu_ready_o ),
        .ld_issue_i ( ld_issue_o  ),
        .st_issue_i ( st_issue_o  )
    );

    // ---------------------------------------------------------------------------
    // stimulus table
    // ---------------------------------------------------------------------------
    task automatic load_table();
        // aligned loads, operand_a filled in from $urandom
        rows[0]  = '{LD, 64'h0, 12'h010, 1'b0, 3'd1, 1'b0, 2'd0, 1'b1,
                     39'h0, 8'hff, 8'h00, 1'b0, 1'b0, 4'd0};
        rows[1]  = '{LW, 64'h0, 12'h008, 1'b0, 3'd2, 1'b0, 2'd2, 1'b1,
                     39'h0, 8'h0f, 8'h00, 1'b0, 1'b0, 4'd0};
        rows[2]  = '{LB, 64'h1003, 12'h000, 1'b0, 3'd3, 1'b0, 2'd1, 1'b0,
                     39'h1003, 8'h08, 8'h00, 1'b0, 1'b0, 4'd0};
        // misaligned loads
        rows[3]  = '{LH, 64'h1001, 12'h000, 1'b0, 3'd4, 1'b0, 2'd1, 1'b0,
                     39'h1001, 8'h06, 8'h00, 1'b0, 1'b1, 4'(`LSU_LD_MISALIGNED)};
        rows[4]  = '{LW, 64'h1000, 12'h002, 1'b0, 3'd5, 1'b0, 2'd0, 1'b0,
                     39'h1002, 8'h3c, 8'h00, 1'b0, 1'b1, 4'(`LSU_LD_MISALIGNED)};
        rows[5]  = '{LD, 64'h1000, 12'h004, 1'b0, 3'd6, 1'b0, 2'd1, 1'b0,
                     39'h1004, 8'hf0, 8'h00, 1'b0, 1'b1, 4'(`LSU_LD_MISALIGNED)};
        // misaligned stores, negative immediate on the first
        rows[6]  = '{SH, 64'h2000, 12'hfff, 1'b0, 3'd7, 1'b0, 2'd0, 1'b0,
                     39'h1fff, 8'h80, 8'h00, 1'b1, 1'b1, 4'(`LSU_ST_MISALIGNED)};
        rows[7]  = '{SW, 64'h2000, 12'h006, 1'b0, 3'd0, 1'b0, 2'd1, 1'b0,
                     39'h2006, 8'hc0, 8'h00, 1'b1, 1'b1, 4'(`LSU_ST_MISALIGNED)};
        rows[8]  = '{SD, 64'h2000, 12'h001, 1'b0, 3'd1, 1'b0, 2'd2, 1'b0,
                     39'h2001, 8'hfe, 8'h00, 1'b1, 1'b1, 4'(`LSU_ST_MISALIGNED)};
        rows[9]  = '{SB, 64'h2007, 12'h000, 1'b0, 3'd2, 1'b0, 2'd0, 1'b0,
                     39'h2007, 8'h80, 8'h00, 1'b1, 1'b0, 4'd0};
        rows[10] = '{SD, 64'h3000, 12'h008, 1'b0, 3'd3, 1'b0, 2'd1, 1'b0,
                     39'h3008, 8'hff, 8'h00, 1'b1, 1'b0, 4'd0};
        rows[11] = '{SW, 64'h3000, 12'h00c, 1'b0, 3'd4, 1'b0, 2'd0, 1'b0,
                     39'h300c, 8'hf0, 8'h00, 1'b1, 1'b0, 4'd0};
        // overflow, access fault wins over misalignment
        rows[12] = '{LD, 64'h40_0000_0000, 12'h003, 1'b0, 3'd5, 1'b1, 2'd0, 1'b0,
                     39'h40_0000_0003, 8'hf8, 8'h00, 1'b0, 1'b1, 4'(`LSU_LD_ACCESS_FAULT)};
        // same overflow, translation off
        rows[13] = '{LD, 64'h40_0000_0000, 12'h000, 1'b0, 3'd6, 1'b0, 2'd1, 1'b0,
                     39'h40_0000_0000, 8'hff, 8'h00, 1'b0, 1'b0, 4'd0};
        rows[14] = '{SW, 64'h8000_0000_0000_0000, 12'h000, 1'b0, 3'd7, 1'b1, 2'd1, 1'b0,
                     39'h0, 8'h0f, 8'h00, 1'b1, 1'b1, 4'(`LSU_ST_ACCESS_FAULT)};
        // coherence hints, owner prediction then cid as upper offset
        rows[15] = '{LD, 64'h1010, 12'h4b8, 1'b1, 3'd0, 1'b0, 2'd0, 1'b0,
                     39'h1008, 8'hff, 8'hcb, 1'b0, 1'b0, 4'd0};
        rows[16] = '{LW, 64'h1000, 12'h344, 1'b1, 3'd1, 1'b0, 2'd1, 1'b0,
                     39'h0fa4, 8'hf0, 8'hb4, 1'b0, 1'b0, 4'd0};
    endtask

    // ---------------------------------------------------------------------------
    // helpers
    // ---------------------------------------------------------------------------
    function automatic logic [63:0] data_of(input row_t r);
        return 64'hd0d0_0000_0000_0000 | 64'(r.tid);
    endfunction

    function automatic lsu_req_t make_req(input row_t r);
        lsu_req_t req;
        req.operator  = r.op;
        req.operand_a = r.a;
        req.operand_b = data_of(r);
        req.imm       = r.imm;
        req.trans_id  = r.tid;
        req.use_dcs   = r.use_dcs;
        return req;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %s got=%h exp=%h", name, got, exp);
        end
    endtask

    task automatic drive_pop(input logic store, input logic en);
        pop_ld_i <= en & ~store;
        pop_st_i <= en & store;
    endtask

    // head of the buffer on the port of its class
    task automatic check_issue(input row_t r);
        lsu_issue_t iss;
        string      pfx;
        string      other;
        iss   = r.store ? st_issue_o : ld_issue_o;
        pfx   = r.store ? "st_issue_o" : "ld_issue_o";
        other = r.store ? "ld_issue_o.valid" : "st_issue_o.valid";
        check({pfx, ".valid"}, 64'(iss.valid), 64'(1'b1));
        check(other, 64'(r.store ? ld_issue_o.valid : st_issue_o.valid), 64'(0));
        check({pfx, ".vaddr"}, 64'(iss.vaddr), 64'(r.vaddr));
        check({pfx, ".be"}, 64'(iss.be), 64'(r.be));
        check({pfx, ".operator"}, 64'(iss.operator), 64'(r.op));
        check({pfx, ".dcs"}, 64'(iss.dcs), 64'(r.dcs));
        check({pfx, ".trans_id"}, 64'(iss.trans_id), 64'(r.tid));
        check({pfx, ".data"}, iss.data, data_of(r));
    endtask

    task automatic check_report(input row_t r);
        lsu_wb_t wb;
        string   pfx;
        wb  = r.store ? st_wb_o : ld_wb_o;
        pfx = r.store ? "st_wb_o" : "ld_wb_o";
        check({pfx, ".valid"}, 64'(wb.valid), 64'(1'b1));
        check({pfx, ".trans_id"}, 64'(wb.trans_id), 64'(r.tid));
        check({pfx, ".ex.valid"}, 64'(wb.ex.valid), 64'(r.ex));
        if (r.ex) begin
            check({pfx, ".ex.cause"}, 64'(wb.ex.cause), 64'(r.cause));
            check({pfx, ".ex.tval"}, 64'(wb.ex.tval), 64'(r.vaddr));
        end
    endtask

    // ---------------------------------------------------------------------------
    // sequences
    // ---------------------------------------------------------------------------
    // one request, popped after hold cycles
    task automatic apply_single(input row_t r);
        @(posedge clk);
        lsu_valid_i            <= 1'b1;
        lsu_req_i              <= make_req(r);
        en_ld_st_translation_i <= r.xlat;
        drive_pop(r.store, r.hold == 2'd0);
        @(negedge clk);
        check("lsu_ready_o", 64'(lsu_ready_o), 64'(1'b1));
        check_issue(r);
        for (int i = 1; i <= int'(r.hold); i++) begin
            @(posedge clk);
            lsu_valid_i <= 1'b0;
            drive_pop(r.store, i == int'(r.hold));
            @(negedge clk);
            // waiting head stays put
            check("lsu_ready_o", 64'(lsu_ready_o), 64'(1'b0));
            check_issue(r);
        end
        @(posedge clk);
        lsu_valid_i <= 1'b0;
        drive_pop(r.store, 1'b0);
        @(negedge clk);
        if (r.store) begin
            // second store stage still in flight
            check("st_wb_o.valid", 64'(st_wb_o.valid), 64'(1'b0));
            @(negedge clk);
        end
        check_report(r);
    endtask

    // two stores queued with pops withheld
    task automatic apply_backpressure(input row_t a, input row_t b);
        @(posedge clk);
        lsu_valid_i            <= 1'b1;
        lsu_req_i              <= make_req(a);
        en_ld_st_translation_i <= a.xlat;
        @(posedge clk);
        // second request lands while the first waits
        lsu_req_i <= make_req(b);
        @(negedge clk);
        check("lsu_ready_o", 64'(lsu_ready_o), 64'(1'b0));
        check_issue(a);
        @(posedge clk);
        lsu_valid_i <= 1'b0;
        @(negedge clk);
        check("lsu_ready_o", 64'(lsu_ready_o), 64'(1'b0));
        check_issue(a);
        @(posedge clk);
        drive_pop(1'b1, 1'b1);
        @(posedge clk);
        drive_pop(1'b1, 1'b0);
        @(negedge clk);
        check("lsu_ready_o", 64'(lsu_ready_o), 64'(1'b0));
        check_issue(b);
        @(posedge clk);
        drive_pop(1'b1, 1'b1);
        @(negedge clk);
        check_report(a);
        @(posedge clk);
        drive_pop(1'b1, 1'b0);
        @(negedge clk);
        check("lsu_ready_o", 64'(lsu_ready_o), 64'(1'b1));
        check("st_issue_o.valid", 64'(st_issue_o.valid), 64'(1'b0));
        @(negedge clk);
        check_report(b);
    endtask

    // fill both entries, then flush
    task automatic apply_flush(input row_t a, input row_t b);
        @(posedge clk);
        lsu_valid_i            <= 1'b1;
        lsu_req_i              <= make_req(a);
        en_ld_st_translation_i <= a.xlat;
        @(posedge clk);
        lsu_req_i <= make_req(b);
        @(posedge clk);
        lsu_valid_i <= 1'b0;
        flush_i     <= 1'b1;
        @(negedge clk);
        check("lsu_ready_o", 64'(lsu_ready_o), 64'(1'b0));
        @(posedge clk);
        flush_i <= 1'b0;
        @(negedge clk);
        check("lsu_ready_o", 64'(lsu_ready_o), 64'(1'b1));
        check("ld_issue_o.valid", 64'(ld_issue_o.valid), 64'(1'b0));
        check("st_issue_o.valid", 64'(st_issue_o.valid), 64'(1'b0));
    endtask

    // ---------------------------------------------------------------------------
    // main run
    // ---------------------------------------------------------------------------
    initial begin
        lsu_valid_i            = 1'b0;
        lsu_req_i              = '0;
        en_ld_st_translation_i = 1'b0;
        pop_ld_i               = 1'b0;
        pop_st_i               = 1'b0;
        flush_i                = 1'b0;
        void'($urandom(32'h58b3));
        load_table();
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].rnd) begin
                // aligned, well below the sign bit of the address
                rows[i].a     = {32'h0, $urandom() & 32'hffff_fff8};
                rows[i].vaddr = `LSU_VLEN'(rows[i].a + {{52{rows[i].imm[11]}}, rows[i].imm});
            end
        end
        wait (rst_n);
        @(negedge clk);
        check("lsu_ready_o", 64'(lsu_ready_o), 64'(1'b1));
        check("ld_issue_o.valid", 64'(ld_issue_o.valid), 64'(1'b0));
        check("st_issue_o.valid", 64'(st_issue_o.valid), 64'(1'b0));
        check("ld_wb_o.valid", 64'(ld_wb_o.valid), 64'(1'b0));
        check("st_wb_o.valid", 64'(st_wb_o.valid), 64'(1'b0));
        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_single(rows[i]);
        end
        apply_backpressure(rows[10], rows[11]);
        apply_flush(rows[2], rows[9]);
        errors += int'(dut.i_asserts.fail_cnt);
        $display("run finished, %0d errors in %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // cycle limit from the table length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout, run still going after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule

//--- verilog.f
+incdir+design
design/lsu_pkg.sv
design/lsu_agu.sv
design/lsu_bypass.sv
design/lsu_dispatch.sv
design/lsu_pipe_reg.sv
design/lsu_front.sv
tb/tb_clock_gen.sv
tb/lsu_front_asserts.sv
tb/tb_lsu_front.sv
